//--- src/ti_mem_pkg.sv
/*
  Shared types and TMS9900 memory-map constants for the memory subsystem.
  All addresses are CPU word addresses, so word 01000 is byte 2000.
  Bank sizes follow the fixed machine map and are not tunable.
*/

package ti_mem_pkg;

  // ==============================
  // Bus types
  // ==============================
  typedef logic [15:0] word_t;  // CPU data word
  typedef logic [7:0]  byte_t;  // Host data byte
  typedef logic [22:0] wadr_t;  // CPU word address (ADR bus)
  typedef logic [23:0] hadr_t;  // Host byte address, bit 0 picks lane

  // Read source, also the registered select in the decoder
  typedef enum logic [2:0] {
    BANK_NONE,
    BANK_ROM,
    BANK_DSR,
    BANK_PAD,
    BANK_GROM,
    BANK_GROM_EXT,
    BANK_CART,
    BANK_RAM_EXP
  } bank_e;

  // ==============================
  // Bank word-address widths
  // ==============================
  localparam int ROM_AW  = 12;  // 8K system ROM
  localparam int DSR_AW  = 12;  // 8K DSR
  localparam int PAD_AW  = 9;   // 1K scratchpad
  localparam int GROM_AW = 14;  // 24K system GROM in a 32K block
  localparam int GEXT_AW = 14;  // 32K GROM extension
  localparam int CART_AW = 15;  // 64K cartridge
  localparam int RAMX_AW = 14;  // 32K RAM expansion

  // Decode tags, compared against upper word-address slices
  localparam logic [10:0] ROM_TAG      = 11'h000;  // ADR[22:12], word 00000
  localparam logic [10:0] RAMX_LO_TAG  = 11'h001;  // ADR[22:12], byte 2000
  localparam logic [10:0] DSR_TAG      = 11'h002;  // ADR[22:12], word 02000
  localparam logic [10:0] RAMX_MID_TAG = 11'h005;  // ADR[22:12], byte A000
  localparam logic [9:0]  RAMX_HI_TAG  = 10'h003;  // ADR[22:13], byte C000-FFFF
  localparam logic [13:0] PAD_TAG      = 14'h0020; // ADR[22:9], word 04000
  localparam logic [7:0]  GROM_TAG     = 8'h01;    // ADR[22:15], words 08000-0FFFF
  localparam logic [7:0]  CART_TAG     = 8'h04;    // ADR[22:15], words 20000-27FFF

endpackage

//--- src/reset_delay.sv
/*
  Power-on reset stretcher for the CPU.
  o_cpu_reset_n rises 2^RESET_DELAY_BITS + 1 cycles after i_arst_n releases.
  i_btn_n is assumed already synchronous to clk.
*/

`timescale 1ns/1ps

module reset_delay #(
  parameter int RESET_DELAY_BITS = 24
) (
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_btn_n,       // Reset button, low when pressed
  output logic o_cpu_reset_n
);

  // One extra bit so the top bit sets after exactly 2^N cycles
  logic [RESET_DELAY_BITS:0] dly_cnt;

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      dly_cnt       <= '0;
      o_cpu_reset_n <= 1'b0;
    end
    else
    begin
      if (!dly_cnt[RESET_DELAY_BITS])
        dly_cnt <= dly_cnt + 1'b1;  // Stops once the top bit is set
      // Reliable start, button can still pull reset at any time
      o_cpu_reset_n <= i_btn_n & dly_cnt[RESET_DELAY_BITS];
    end
  end

endmodule

//--- src/host_bridge.sv
/*
  Host loader bridge onto the shared memory port.
  Four-phase req/ack, one byte per transfer. Hold req, we, addr, wdata stable
  until ack. CPU always has priority; a host access waits for a cycle with
  i_oe_n and i_we_n both high and may wait forever if the CPU never idles.
*/

`timescale 1ns/1ps

module host_bridge (
  input  logic                clk,
  input  logic                i_arst_n,
  // CPU bus
  input  ti_mem_pkg::wadr_t   i_adr,
  input  logic                i_oe_n,
  input  logic                i_we_n,
  input  logic                i_lb_n,
  input  logic                i_ub_n,
  input  ti_mem_pkg::word_t   i_wdata,
  // Host request
  input  logic                i_host_req,
  input  logic                i_host_we,
  input  ti_mem_pkg::hadr_t   i_host_addr,
  input  ti_mem_pkg::byte_t   i_host_wdata,
  // Read word back from the decoder
  input  ti_mem_pkg::word_t   i_rdata,
  output logic                o_host_ack,
  output ti_mem_pkg::byte_t   o_host_rdata,
  // Shared memory port with active-high strobes
  output ti_mem_pkg::wadr_t   m_adr,
  output logic                m_we,
  output logic                m_lb,
  output logic                m_ub,
  output ti_mem_pkg::word_t   m_wdata,
  output logic                m_host
);

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    DATA,
    ACK
  } state_e;

  state_e state;
  state_e state_nxt;
  logic   bus_idle;
  logic   grant;

  assign bus_idle = i_oe_n & i_we_n;
  assign grant    = (state == ACCESS) && bus_idle;  // Only when the CPU is quiet

  // ==============================
  // Handshake FSM
  // ==============================
  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:    if (i_host_req) state_nxt = ACCESS;
      ACCESS:  if (bus_idle)   state_nxt = DATA;   // Access edge
      DATA:                    state_nxt = ACK;    // Read word valid now
      ACK:     if (!i_host_req) state_nxt = IDLE;
      default:                 state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  assign o_host_ack = (state == ACK);

  // High byte is captured when bit 0 is clear (big-endian)
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      o_host_rdata <= '0;
    else if (state == DATA)
      o_host_rdata <= i_host_addr[0] ? i_rdata[7:0] : i_rdata[15:8];
  end

  // ==============================
  // Port mux
  // ==============================
  assign m_host  = grant;
  assign m_adr   = grant ? i_host_addr[23:1] : i_adr;
  assign m_we    = grant ? i_host_we : ~i_we_n;
  assign m_ub    = grant ? ~i_host_addr[0] : ~i_ub_n;
  assign m_lb    = grant ? i_host_addr[0] : ~i_lb_n;
  assign m_wdata = grant ? {i_host_wdata, i_host_wdata} : i_wdata;  // Byte on both lanes

endmodule

//--- src/mem_decode.sv
/*
  Word-address decode of the TI-99/4A map onto the seven on-chip banks.
  Reads always run; o_rdata belongs to the address of the previous cycle.
  ROM and system GROM accept writes only from the host port.
*/

`timescale 1ns/1ps

module mem_decode (
  input  logic                                clk,
  input  logic                                i_arst_n,
  // Shared port
  input  ti_mem_pkg::wadr_t                   m_adr,
  input  logic                                m_we,
  input  logic                                m_lb,
  input  logic                                m_ub,
  input  logic                                m_host,
  // Bank addresses and lane write enables
  output logic [ti_mem_pkg::ROM_AW-1:0]       o_rom_addr,
  output logic                                o_rom_we_hi, o_rom_we_lo,
  output logic [ti_mem_pkg::DSR_AW-1:0]       o_dsr_addr,
  output logic                                o_dsr_we_hi, o_dsr_we_lo,
  output logic [ti_mem_pkg::PAD_AW-1:0]       o_pad_addr,
  output logic                                o_pad_we_hi, o_pad_we_lo,
  output logic [ti_mem_pkg::GROM_AW-1:0]      o_grom_addr,
  output logic                                o_grom_we_hi, o_grom_we_lo,
  output logic [ti_mem_pkg::GEXT_AW-1:0]      o_gext_addr,
  output logic                                o_gext_we_hi, o_gext_we_lo,
  output logic [ti_mem_pkg::CART_AW-1:0]      o_cart_addr,
  output logic                                o_cart_we_hi, o_cart_we_lo,
  output logic [ti_mem_pkg::RAMX_AW-1:0]      o_ramx_addr,
  output logic                                o_ramx_we_hi, o_ramx_we_lo,
  // Bank read words
  input  ti_mem_pkg::word_t                   i_rom_rdata,
  input  ti_mem_pkg::word_t                   i_dsr_rdata,
  input  ti_mem_pkg::word_t                   i_pad_rdata,
  input  ti_mem_pkg::word_t                   i_grom_rdata,
  input  ti_mem_pkg::word_t                   i_gext_rdata,
  input  ti_mem_pkg::word_t                   i_cart_rdata,
  input  ti_mem_pkg::word_t                   i_ramx_rdata,
  output ti_mem_pkg::word_t                   o_rdata
);

  import ti_mem_pkg::*;

  bank_e sel;
  bank_e sel_q;     // Bank that the RAMs are answering for
  logic  gext_win;  // GROM windows 3..6 go to the extension
  logic  ramx_hit;
  logic  wr_hi;
  logic  wr_lo;

  // ==============================
  // Map decode
  // ==============================
  assign gext_win = (m_adr[14:12] >= 3'd3) && (m_adr[14:12] <= 3'd6);
  assign ramx_hit = (m_adr[22:12] == RAMX_LO_TAG) || (m_adr[22:12] == RAMX_MID_TAG)
                 || (m_adr[22:13] == RAMX_HI_TAG);

  always_comb
  begin
    sel = BANK_NONE;  // Unmapped reads as zero
    if (m_adr[22:12] == ROM_TAG)       sel = BANK_ROM;
    else if (m_adr[22:12] == DSR_TAG)  sel = BANK_DSR;
    else if (m_adr[22:9] == PAD_TAG)   sel = BANK_PAD;
    else if (m_adr[22:15] == GROM_TAG) sel = gext_win ? BANK_GROM_EXT : BANK_GROM;
    else if (m_adr[22:15] == CART_TAG) sel = BANK_CART;
    else if (ramx_hit)                 sel = BANK_RAM_EXP;
  end

  assign wr_hi = m_we & m_ub;
  assign wr_lo = m_we & m_lb;

  // Loader-only banks need m_host
  assign o_rom_we_hi  = (sel == BANK_ROM) & wr_hi & m_host;
  assign o_rom_we_lo  = (sel == BANK_ROM) & wr_lo & m_host;
  assign o_grom_we_hi = (sel == BANK_GROM) & wr_hi & m_host;
  assign o_grom_we_lo = (sel == BANK_GROM) & wr_lo & m_host;
  assign o_dsr_we_hi  = (sel == BANK_DSR) & wr_hi;
  assign o_dsr_we_lo  = (sel == BANK_DSR) & wr_lo;
  assign o_pad_we_hi  = (sel == BANK_PAD) & wr_hi;
  assign o_pad_we_lo  = (sel == BANK_PAD) & wr_lo;
  assign o_gext_we_hi = (sel == BANK_GROM_EXT) & wr_hi;
  assign o_gext_we_lo = (sel == BANK_GROM_EXT) & wr_lo;
  assign o_cart_we_hi = (sel == BANK_CART) & wr_hi;
  assign o_cart_we_lo = (sel == BANK_CART) & wr_lo;
  assign o_ramx_we_hi = (sel == BANK_RAM_EXP) & wr_hi;
  assign o_ramx_we_lo = (sel == BANK_RAM_EXP) & wr_lo;

  // Bank addresses, plain low slices
  assign o_rom_addr  = m_adr[ROM_AW-1:0];
  assign o_dsr_addr  = m_adr[DSR_AW-1:0];
  assign o_pad_addr  = m_adr[PAD_AW-1:0];
  assign o_grom_addr = m_adr[GROM_AW-1:0];
  assign o_gext_addr = m_adr[GEXT_AW-1:0];  // Windows 3..6 stay distinct in [13:12]
  assign o_cart_addr = m_adr[CART_AW-1:0];
  // 2000 window folds to the bottom 8K, A000 and C000 keep [13:12]
  assign o_ramx_addr = {(m_adr[14:12] == 3'b001) ? 2'b00 : m_adr[13:12], m_adr[11:0]};

  // ==============================
  // Registered read select
  // ==============================
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      sel_q <= BANK_NONE;
    else
      sel_q <= sel;  // Lines up with the one-cycle RAM read
  end

  always_comb
  begin
    case (sel_q)
      BANK_ROM:      o_rdata = i_rom_rdata;
      BANK_DSR:      o_rdata = i_dsr_rdata;
      BANK_PAD:      o_rdata = i_pad_rdata;
      BANK_GROM:     o_rdata = i_grom_rdata;
      BANK_GROM_EXT: o_rdata = i_gext_rdata;
      BANK_CART:     o_rdata = i_cart_rdata;
      BANK_RAM_EXP:  o_rdata = i_ramx_rdata;
      default:       o_rdata = '0;
    endcase
  end

endmodule

//--- src/byte_lane_ram.sv
/*
  Word-wide block RAM built from two byte lanes.
  Read is synchronous with one cycle of latency; contents power up unknown.
*/

`timescale 1ns/1ps

module byte_lane_ram #(
  parameter int AW = 12
) (
  input  logic              clk,
  input  logic [AW-1:0]     i_addr,
  input  logic              i_we_hi,  // Lane 15:8
  input  logic              i_we_lo,  // Lane 7:0
  input  ti_mem_pkg::word_t i_wdata,
  output ti_mem_pkg::word_t o_rdata
);

  import ti_mem_pkg::*;

  byte_t mem_hi [0:(2**AW)-1];
  byte_t mem_lo [0:(2**AW)-1];

  always_ff @(posedge clk)
  begin
    if (i_we_hi)
      mem_hi[i_addr] <= i_wdata[15:8];
    if (i_we_lo)
      mem_lo[i_addr] <= i_wdata[7:0];
    o_rdata <= {mem_hi[i_addr], mem_lo[i_addr]};  // Old data on a write cycle
  end

endmodule

//--- src/ti_mem_top.sv
/*
  TI-99/4A memory subsystem top: seven on-chip banks behind the CPU bus,
  a host loader port and the CPU reset delay.
  Strobes on the CPU side are active low, one clock domain throughout.
*/

`timescale 1ns/1ps

module ti_mem_top #(
  parameter int RESET_DELAY_BITS = 24
) (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_btn_n,
  // CPU memory bus
  input  ti_mem_pkg::wadr_t i_adr,
  input  logic              i_oe_n,
  input  logic              i_we_n,
  input  logic              i_lb_n,
  input  logic              i_ub_n,
  input  ti_mem_pkg::word_t i_wdata,
  output ti_mem_pkg::word_t o_rdata,
  // Host loader
  input  logic              i_host_req,
  input  logic              i_host_we,
  input  ti_mem_pkg::hadr_t i_host_addr,
  input  ti_mem_pkg::byte_t i_host_wdata,
  output logic              o_host_ack,
  output ti_mem_pkg::byte_t o_host_rdata,
  output logic              o_cpu_reset_n
);

  import ti_mem_pkg::*;

  // Shared port
  wadr_t m_adr;
  word_t m_wdata;
  logic  m_we, m_lb, m_ub, m_host;

  // ==============================
  // Bank wiring
  // ==============================
  logic [ROM_AW-1:0]  rom_addr;
  logic [DSR_AW-1:0]  dsr_addr;
  logic [PAD_AW-1:0]  pad_addr;
  logic [GROM_AW-1:0] grom_addr;
  logic [GEXT_AW-1:0] gext_addr;
  logic [CART_AW-1:0] cart_addr;
  logic [RAMX_AW-1:0] ramx_addr;
  logic rom_we_hi, rom_we_lo, dsr_we_hi, dsr_we_lo, pad_we_hi, pad_we_lo;
  logic grom_we_hi, grom_we_lo, gext_we_hi, gext_we_lo;
  logic cart_we_hi, cart_we_lo, ramx_we_hi, ramx_we_lo;
  word_t rom_rdata, dsr_rdata, pad_rdata, grom_rdata, gext_rdata, cart_rdata, ramx_rdata;

  host_bridge u_host_bridge (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_adr(i_adr), .i_oe_n(i_oe_n), .i_we_n(i_we_n),
    .i_lb_n(i_lb_n), .i_ub_n(i_ub_n), .i_wdata(i_wdata),
    .i_host_req(i_host_req), .i_host_we(i_host_we),
    .i_host_addr(i_host_addr), .i_host_wdata(i_host_wdata),
    .i_rdata(o_rdata), .o_host_ack(o_host_ack), .o_host_rdata(o_host_rdata),
    .m_adr(m_adr), .m_we(m_we), .m_lb(m_lb), .m_ub(m_ub),
    .m_wdata(m_wdata), .m_host(m_host)
  );

  mem_decode u_mem_decode (
    .clk(clk), .i_arst_n(i_arst_n),
    .m_adr(m_adr), .m_we(m_we), .m_lb(m_lb), .m_ub(m_ub), .m_host(m_host),
    .o_rom_addr(rom_addr),   .o_rom_we_hi(rom_we_hi),   .o_rom_we_lo(rom_we_lo),
    .o_dsr_addr(dsr_addr),   .o_dsr_we_hi(dsr_we_hi),   .o_dsr_we_lo(dsr_we_lo),
    .o_pad_addr(pad_addr),   .o_pad_we_hi(pad_we_hi),   .o_pad_we_lo(pad_we_lo),
    .o_grom_addr(grom_addr), .o_grom_we_hi(grom_we_hi), .o_grom_we_lo(grom_we_lo),
    .o_gext_addr(gext_addr), .o_gext_we_hi(gext_we_hi), .o_gext_we_lo(gext_we_lo),
    .o_cart_addr(cart_addr), .o_cart_we_hi(cart_we_hi), .o_cart_we_lo(cart_we_lo),
    .o_ramx_addr(ramx_addr), .o_ramx_we_hi(ramx_we_hi), .o_ramx_we_lo(ramx_we_lo),
    .i_rom_rdata(rom_rdata), .i_dsr_rdata(dsr_rdata), .i_pad_rdata(pad_rdata),
    .i_grom_rdata(grom_rdata), .i_gext_rdata(gext_rdata),
    .i_cart_rdata(cart_rdata), .i_ramx_rdata(ramx_rdata),
    .o_rdata(o_rdata)
  );

  // All banks share the port write word
  byte_lane_ram #(.AW(ROM_AW)) u_rom (.clk(clk), .i_addr(rom_addr), .i_we_hi(rom_we_hi),
    .i_we_lo(rom_we_lo), .i_wdata(m_wdata), .o_rdata(rom_rdata));
  byte_lane_ram #(.AW(DSR_AW)) u_dsr (.clk(clk), .i_addr(dsr_addr), .i_we_hi(dsr_we_hi),
    .i_we_lo(dsr_we_lo), .i_wdata(m_wdata), .o_rdata(dsr_rdata));
  byte_lane_ram #(.AW(PAD_AW)) u_pad (.clk(clk), .i_addr(pad_addr), .i_we_hi(pad_we_hi),
    .i_we_lo(pad_we_lo), .i_wdata(m_wdata), .o_rdata(pad_rdata));
  byte_lane_ram #(.AW(GROM_AW)) u_grom (.clk(clk), .i_addr(grom_addr), .i_we_hi(grom_we_hi),
    .i_we_lo(grom_we_lo), .i_wdata(m_wdata), .o_rdata(grom_rdata));
  byte_lane_ram #(.AW(GEXT_AW)) u_gext (.clk(clk), .i_addr(gext_addr), .i_we_hi(gext_we_hi),
    .i_we_lo(gext_we_lo), .i_wdata(m_wdata), .o_rdata(gext_rdata));
  byte_lane_ram #(.AW(CART_AW)) u_cart (.clk(clk), .i_addr(cart_addr), .i_we_hi(cart_we_hi),
    .i_we_lo(cart_we_lo), .i_wdata(m_wdata), .o_rdata(cart_rdata));
  byte_lane_ram #(.AW(RAMX_AW)) u_ramx (.clk(clk), .i_addr(ramx_addr), .i_we_hi(ramx_we_hi),
    .i_we_lo(ramx_we_lo), .i_wdata(m_wdata), .o_rdata(ramx_rdata));

  reset_delay #(.RESET_DELAY_BITS(RESET_DELAY_BITS)) u_reset_delay (
    .clk(clk), .i_arst_n(i_arst_n), .i_btn_n(i_btn_n), .o_cpu_reset_n(o_cpu_reset_n)
  );

endmodule

//--- verification/tb_ti_mem_tasks.svh
/*
  CPU and host bus tasks, random numbers and the memory model for tb_ti_mem.
  Included inside the testbench module body, after its signal declarations.
*/

`ifndef TB_TI_MEM_TASKS_SVH
`define TB_TI_MEM_TASKS_SVH

  logic [31:0] lcg_state = 32'h65474414;
  byte_t       mdl [int];  // Byte model, index = key*2 + 1 for the high lane

  // LCG step, upper bits are the better ones
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // CPU write, lane strobes active low
  task automatic cpu_write(input wadr_t a, input word_t d, input logic lb, input logic ub);
    @(posedge clk);
    adr   <= a;
    wdata <= d;
    lb_n  <= lb;
    ub_n  <= ub;
    we_n  <= 1'b0;  // Commits on the next edge
    @(posedge clk);
    we_n  <= 1'b1;
    lb_n  <= 1'b1;
    ub_n  <= 1'b1;
  endtask

  // CPU read, the monitor checks the word one cycle later
  task automatic cpu_read(input wadr_t a);
    @(posedge clk);
    adr  <= a;
    oe_n <= 1'b0;
    @(posedge clk);
    oe_n <= 1'b1;
  endtask

  // One four-phase host transfer
  task automatic host_access(input logic we, input hadr_t a, input byte_t d,
                             output byte_t rd);
    int n;
    int k;
    n = 0;
    @(posedge clk);
    host_req   <= 1'b1;
    host_we    <= we;
    host_addr  <= a;
    host_wdata <= d;
    @(negedge clk);
    while (!host_ack && n < HS_WAIT)
    begin
      n++;
      @(negedge clk);
    end
    if (!host_ack)
    begin
      $display("Host access at %0t got no acknowledge within %0d cycles", $time, HS_WAIT);
      err_cnt++;
    end
    else if (we)
    begin
      k = mem_key(a[23:1]);
      if (k >= 0)
        mdl[k * 2 + (a[0] ? 0 : 1)] = d;  // Bit 0 clear is the high byte
    end
    rd = host_rdata;
    @(posedge clk);
    host_req <= 1'b0;
    @(negedge clk);
    n = 0;
    while (host_ack && n < HS_WAIT)
    begin
      n++;
      @(negedge clk);
    end
  endtask

`endif

//--- verification/tb_ti_mem.sv
/*
  Testbench for the TI-99/4A memory subsystem, reset delay set to 4 bits.
  A negedge monitor checks reads and the host handshake against a byte model.
  Model entries never written are not compared, except unmapped reads.
*/

`timescale 1ns/1ps

module tb_ti_mem;

  import ti_mem_pkg::*;

  // ==============================
  // Limits
  // ==============================
  localparam int HS_WAIT  = 200;        // Per-handshake wait
  localparam int T_RESET  = 80;
  localparam int T_RAM    = 4 * 16 * 12;
  localparam int T_FOLD   = 40;
  localparam int T_LOAD   = 16 * 20 + 60;
  localparam int T_HS     = 60;
  localparam int T_UNMAP  = 30;
  localparam int T_LIMIT  = T_RESET + T_RAM + T_FOLD + T_LOAD + T_HS + T_UNMAP + 500;

  logic  clk;
  logic  arst_n, btn_n;
  wadr_t adr;
  logic  oe_n, we_n, lb_n, ub_n;
  word_t wdata, rdata;
  logic  host_req, host_we, host_ack, cpu_reset_n;
  hadr_t host_addr;
  byte_t host_wdata, host_rdata;

  int err_cnt = 0;
  int test_err;
  int cyc_cnt = 0;

  // Bank*2^20 + offset of a CPU word address, or -1 when unmapped
  function automatic int mem_key(input wadr_t a);
    int k;
    k = -1;
    if (a < 23'h01000)
      k = (1 << 20) + a[11:0];                  // System ROM
    else if (a < 23'h02000)
      k = (7 << 20) + a[11:0];                  // Byte 2000 window at the bottom of RAM
    else if (a < 23'h03000)
      k = (2 << 20) + a[11:0];                  // DSR
    else if (a >= 23'h04000 && a < 23'h04200)
      k = (3 << 20) + a[8:0];                   // Scratchpad
    else if (a >= 23'h05000 && a < 23'h06000)
      k = (7 << 20) + 32'h1000 + a[11:0];       // Byte A000
    else if (a >= 23'h06000 && a < 23'h08000)
      k = (7 << 20) + 32'h2000 + a[12:0];
    else if (a >= 23'h08000 && a < 23'h10000)
      k = ((a[14:12] >= 3 && a[14:12] <= 6) ? (5 << 20) : (4 << 20)) + a[13:0];
    else if (a >= 23'h20000 && a < 23'h28000)
      k = (6 << 20) + a[14:0];                  // Cartridge
    return k;
  endfunction

  `include "tb_ti_mem_tasks.svh"

  ti_mem_top #(.RESET_DELAY_BITS(4)) u_ti_mem_top (
    .clk(clk), .i_arst_n(arst_n), .i_btn_n(btn_n),
    .i_adr(adr), .i_oe_n(oe_n), .i_we_n(we_n), .i_lb_n(lb_n), .i_ub_n(ub_n),
    .i_wdata(wdata), .o_rdata(rdata),
    .i_host_req(host_req), .i_host_we(host_we), .i_host_addr(host_addr),
    .i_host_wdata(host_wdata), .o_host_ack(host_ack), .o_host_rdata(host_rdata),
    .o_cpu_reset_n(cpu_reset_n)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ==============================
  // Checking monitor
  // ==============================
  logic  rd_pend = 1'b0;
  word_t rd_exp;
  int    req_cyc = 0;
  logic  busy_seen = 1'b0, idle_seen = 1'b0, ack_q = 1'b0;

  always @(negedge clk)
  begin
    int k;
    if (arst_n)
    begin
      // Read word for last cycle's address
      if (rd_pend)
        assert (rdata === rd_exp)
        else begin
          $display("[FAIL] %0t read got %h, expected %h", $time, rdata, rd_exp);
          err_cnt++;
        end
      rd_pend = 1'b0;
      k = mem_key(adr);
      if (!oe_n)
      begin
        if (k < 0)
        begin
          rd_pend = 1'b1;
          rd_exp  = '0;  // Unmapped
        end
        else if (mdl.exists(k * 2) && mdl.exists(k * 2 + 1))
        begin
          rd_pend = 1'b1;
          rd_exp  = {mdl[k * 2 + 1], mdl[k * 2]};
        end
      end
      // ROM and system GROM ignore CPU writes
      if (!we_n && k >= 0 && (k >> 20) != 1 && (k >> 20) != 4)
      begin
        if (!ub_n) mdl[k * 2 + 1] = wdata[15:8];
        if (!lb_n) mdl[k * 2]     = wdata[7:0];
      end
      // Handshake tracking
      if (host_req && !host_ack)
      begin
        req_cyc++;
        if (!(oe_n && we_n)) busy_seen = 1'b1;
        else                 idle_seen = 1'b1;
      end
      if (host_ack && !ack_q)
      begin
        assert (idle_seen)
        else begin
          $display("[FAIL] %0t ack while the CPU held the bus", $time);
          err_cnt++;
        end
        if (!busy_seen)
          assert (req_cyc == 3)
          else begin
            $display("[FAIL] %0t ack after %0d cycles, expected 3", $time, req_cyc);
            err_cnt++;
          end
      end
      if (ack_q && !host_ack)
        assert (!host_req)
        else begin
          $display("[FAIL] %0t ack dropped with request still high", $time);
          err_cnt++;
        end
      if (!host_req && !host_ack)
      begin
        req_cyc   = 0;
        busy_seen = 1'b0;
        idle_seen = 1'b0;
      end
      ack_q = host_ack;
    end
  end

  // Timeout
  always @(posedge clk)
  begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= T_LIMIT)
    begin
      $display("Timeout: run did not finish within %0d cycles", T_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic end_test(input string name);
    $display("%s: %0d errors", name, err_cnt - test_err);
    test_err = err_cnt;
  endtask

  task automatic check(input logic ok, input string msg);
    assert (ok)
    else begin
      $display("[FAIL] %0t %s", $time, msg);
      err_cnt++;
    end
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial
  begin
    int    n;
    wadr_t a;
    word_t d;
    byte_t rb;
    logic [31:0] r;
    arst_n     = 1'b0;
    btn_n      = 1'b1;
    adr        = '0;
    oe_n       = 1'b1;
    we_n       = 1'b1;
    lb_n       = 1'b1;
    ub_n       = 1'b1;
    wdata      = '0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    test_err   = 0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    // Test 1 checks the reset delay and the button
    n = 0;
    @(negedge clk);
    check(!host_ack && rdata == '0, "ack or read word not clear after reset");
    while (!cpu_reset_n && n < 60)
    begin
      n++;
      @(negedge clk);
    end
    check(n == 17, "CPU reset release not 17 cycles after reset");
    @(posedge clk);
    btn_n <= 1'b0;
    @(negedge clk);
    check(cpu_reset_n, "CPU reset fell too early");
    @(negedge clk);
    check(!cpu_reset_n, "CPU reset did not follow the button");
    @(posedge clk);
    btn_n <= 1'b1;
    repeat (3) @(negedge clk);
    check(cpu_reset_n, "CPU reset stuck low after button release");
    end_test("reset");
    // Test 2 does RAM round trips with lane strobes
    for (int b = 0; b < 4; b++)
      for (int i = 0; i < 16; i++)
      begin
        r = lcg_next();
        case (b)
          0: a = 23'h20000 + r[14:0];
          1: a = 23'h02000 + r[11:0];
          2: a = 23'h04000 + r[8:0];
          default: a = 23'h08000 + ((3 + r[17:16]) << 12) + r[11:0];
        endcase
        r = lcg_next();
        d = r[23:8];
        cpu_write(a, d, 1'b0, 1'b0);
        r = lcg_next();
        cpu_write(a, r[31:16], r[3], r[5]);  // Random lanes
        cpu_read(a);
      end
    end_test("cpu_ram");
    // Test 3 covers RAM expansion folding
    r = lcg_next();
    a = 23'h01000 + r[11:0];
    cpu_write(a, 16'h2a5c, 1'b0, 1'b0);
    cpu_read(a);
    cpu_write(23'h05000 + r[11:0], 16'hd3e1, 1'b0, 1'b0);
    cpu_read(a);
    cpu_read(23'h05000 + r[11:0]);
    end_test("ramx_fold");
    // Test 4 loads ROM and GROM from the host
    for (int i = 0; i < 8; i++)
    begin
      r = lcg_next();
      a = (i < 4) ? {11'd0, r[11:0]} : 23'h08000 + ((r[13:12] % 3) << 12) + r[11:0];
      host_access(1'b1, {a, 1'b0}, r[31:24], rb);
      host_access(1'b1, {a, 1'b1}, r[23:16], rb);
      cpu_read(a);
      host_access(1'b0, {a, 1'b0}, 8'h00, rb);
      check(rb === r[31:24], "host read of high byte wrong");
      host_access(1'b0, {a, 1'b1}, 8'h00, rb);
      check(rb === r[23:16], "host read of low byte wrong");
      if (i == 0)
      begin
        cpu_write(a, ~r[31:16], 1'b0, 1'b0);  // ROM is read only to the CPU
        cpu_read(a);
      end
    end
    end_test("host_loader");
    // Test 5 runs back-pressure and then an idle handshake
    @(posedge clk);
    adr  <= 23'h20010;
    oe_n <= 1'b0;
    @(posedge clk);
    host_req  <= 1'b1;
    host_we   <= 1'b0;
    host_addr <= {23'h20010, 1'b0};
    repeat (10)
    begin
      @(negedge clk);
      check(!host_ack, "ack while the CPU bus was busy");
    end
    @(posedge clk);
    oe_n <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!host_ack && n < HS_WAIT)
    begin
      n++;
      @(negedge clk);
    end
    check(host_ack, "no ack after the bus went idle");
    @(posedge clk);
    host_req <= 1'b0;
    @(negedge clk);
    check(host_ack, "ack dropped in the same cycle as the request");
    @(negedge clk);
    check(!host_ack, "ack did not drop after the request");
    host_access(1'b0, {23'h04001, 1'b1}, 8'h00, rb);
    end_test("handshake");
    // Test 6 reads unmapped addresses
    cpu_read(23'h03000);
    cpu_read(23'h04800);
    cpu_read(23'h10000);
    cpu_read(23'h30000);
    cpu_read(23'h7fffff);
    repeat (3) @(posedge clk);
    end_test("unmapped");
    $display("Checks done, %0d errors in %0d cycles", err_cnt, cyc_cnt);
    if (err_cnt == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- all.f
+incdir+verification
src/ti_mem_pkg.sv
src/reset_delay.sv
src/host_bridge.sv
src/mem_decode.sv
src/byte_lane_ram.sv
src/ti_mem_top.sv
verification/tb_ti_mem.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_ti_mem
FILELIST = all.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o Vsim
	./obj_dir/Vsim | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
